//--- vlog.f
+incdir+common
common/fir_data_pkg.sv
common/fir_coeff_pkg.sv
fir_core/fir_fold_line.sv
fir_core/fir_mac_tree.sv
design/fir_valid_track.sv
design/fir_filter.sv
tests/fir_filter_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the FIR filter testbench with Verilator and runs it
# the run counts as failed if the log holds the failure line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fir_filter_sim
LOG=sim.log

verilator --binary --timing \
	--top-module fir_filter_tb \
	-f vlog.f \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "build step returned an error"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
	echo "simulation reported a failing check"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation run finished cleanly"
exit 0

//--- tests/fir_tests.txt
# columns: command value count, or: expect value
# idle, impulse, step, gap (enable dropped at random), random
# expect lines give literal outputs for the last samples of the command above
idle 0 20
impulse -131072 45
expect -88
expect 0
expect 97
expect 197
expect 294
expect 380
expect 447
expect 490
expect 504
expect 481
expect 420
expect 319
expect 178
expect 0
expect -212
expect -451
expect -710
expect -980
expect -1252
expect -1514
expect -1756
expect -1971
expect -2147
expect -1971
expect -1756
expect -1514
expect -1252
expect -980
expect -710
expect -451
expect -212
expect 0
expect 178
expect 319
expect 420
expect 481
expect 504
expect 490
expect 447
expect 380
expect 294
expect 197
expect 97
expect 0
expect -88
idle 0 12
# settled step output is value * 12401 / 2^17, rounded down
step 65536 60
expect 6200
step -65536 60
expect -6201
step 131071 60
expect 12400
idle 0 12
gap 0 120
random 0 200
idle 0 12

//--- tests/fir_filter_tb.sv
// testbench for the 45-tap FIR filter
// runs commands from a data file, checks every enabled output against
// a reference model and against the literal values in the file

`timescale 1ns/100ps
`default_nettype none

`include "fir_macros.svh"

module fir_filter_tb;

	import fir_data_pkg::*;
	import fir_coeff_pkg::*;

	typedef logic [8*12-1:0] word_t;

	// one expected output and the enabled-edge count it is due at
	typedef struct packed {
		int      due;
		logic    valid;
		sample_t value;
		logic    has_lit;
		sample_t lit;
	} expect_t;

	logic        clk;
	logic        reset;
	logic        i_clk_ena;
	logic        i_valid;
	sample_t     i_sample;
	logic        o_valid;
	sample_t     o_sample;

	sample_t     hist [`FIR_NUM_TAPS];
	expect_t     exp_q [$];
	int          pending_valid;
	int          ena_count;
	int          seen_count;
	logic        held_valid;
	sample_t     held_sample;
	logic [31:0] lfsr;

	// parsed test file
	word_t       cmd_word [$];
	int          cmd_value [$];
	int          cmd_count [$];
	int          cmd_lit_start [$];
	int          cmd_lit_num [$];
	sample_t     lit_list [$];

	fir_filter dut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_valid   (o_valid),
		.o_sample  (o_sample)
	);

	always #20 clk = ~clk;

	// enabled edges since reset give the model its time base
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			ena_count <= 0;
		end else if (i_clk_ena) begin
			ena_count <= ena_count + 1;
		end
	end

	// ******************************
	// checks
	// ******************************

	task automatic stop_with_failure(input string reason);
		$display("%0s", reason);
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sample(input sample_t actual, input sample_t expected,
			input string what);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH at time %0t: %0s, got %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_valid(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH at time %0t: %0s, got %0b, expected %0b",
				$time, what, actual, expected));
		end
	endtask

	// ******************************
	// model and random data
	// ******************************

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// fills from the low bit with one step per bit
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			bits[b] = lfsr[0];
		end
	endtask

	// sum of c(k) * x(n-k) shifted down by 2^17 with the low bits kept
	function automatic sample_t model_output();
		longint acc;
		longint coeff;
		acc = 0;
		for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
			if (k < `FIR_NUM_UNIQ) begin
				coeff = longint'(FIR_COEFFS[k]);
			end else begin
				coeff = longint'(FIR_COEFFS[`FIR_NUM_TAPS - 1 - k]);
			end
			acc += coeff * longint'(hist[k]);
		end
		acc = acc >>> `FIR_SCALE_SHIFT;
		return sample_t'(acc[`FIR_DATA_W-1:0]);
	endfunction

	// drives one falling edge and steps the model along with the DUT
	task automatic drive_cycle(input logic ena, input logic valid, input sample_t sample,
			input logic has_lit, input sample_t lit);
		expect_t e;
		@(negedge clk);
		i_clk_ena = ena;
		i_valid = valid;
		i_sample = sample;
		if (ena) begin
			for (int k = `FIR_NUM_TAPS - 1; k > 0; k--) begin
				hist[k] = hist[k - 1];
			end
			hist[0] = sample;
			e.due = ena_count + `FIR_LATENCY;
			e.valid = valid;
			e.value = model_output();
			e.has_lit = has_lit;
			e.lit = lit;
			exp_q.push_back(e);
			if (valid) begin
				pending_valid++;
			end
		end
	endtask

	// outputs are checked once per enabled edge and must hold in between
	always @(negedge clk) begin
		if (!reset) begin
			if (ena_count != seen_count) begin
				seen_count = ena_count;
				if (exp_q.size() > 0 && exp_q[0].due == ena_count) begin
					check_valid(o_valid, exp_q[0].valid, "o_valid after 9 enabled cycles");
					check_sample(o_sample, exp_q[0].value, "o_sample against model");
					if (exp_q[0].has_lit) begin
						check_sample(o_sample, exp_q[0].lit, "o_sample against file value");
					end
					if (exp_q[0].valid) begin
						pending_valid--;
					end
					void'(exp_q.pop_front());
				end else begin
					// pipeline still holds reset values
					check_valid(o_valid, 1'b0, "o_valid while pipeline fills");
					check_sample(o_sample, '0, "o_sample while pipeline fills");
				end
				held_valid = o_valid;
				held_sample = o_sample;
			end else begin
				check_valid(o_valid, held_valid, "o_valid held with enable low");
				check_sample(o_sample, held_sample, "o_sample held with enable low");
			end
		end
	end

	// ******************************
	// test file
	// ******************************

	task automatic load_tests();
		int               fd;
		int               n;
		int               a;
		int               b;
		word_t            word;
		logic [8*120-1:0] line;
		fd = $fopen("tests/fir_tests.txt", "r");
		if (fd == 0) begin
			stop_with_failure("could not open the test file tests/fir_tests.txt");
		end
		while (!$feof(fd)) begin
			line = '0;
			word = '0;
			n = $fgets(line, fd);
			n = $sscanf(line, "%s %d %d", word, a, b);
			if (n >= 2 && word == word_t'("expect")) begin
				if (cmd_word.size() == 0) begin
					stop_with_failure("test file has an expect line before any command");
				end
				lit_list.push_back(sample_t'(a));
				cmd_lit_num[cmd_lit_num.size() - 1]++;
			end else if (n == 3) begin
				cmd_word.push_back(word);
				cmd_value.push_back(a);
				cmd_count.push_back(b);
				cmd_lit_start.push_back(lit_list.size());
				cmd_lit_num.push_back(0);
			end else if (n > 0 && word != word_t'("#")) begin
				stop_with_failure($sformatf("test file line not understood: %0s", line));
			end
		end
		$fclose(fd);
	endtask

	task automatic run_command(input int idx);
		word_t       word;
		int          lit_first;
		int          gap_len;
		logic        has_lit;
		sample_t     lit;
		logic [31:0] bits;
		word = cmd_word[idx];
		lit_first = cmd_count[idx] - cmd_lit_num[idx];
		if (lit_first < 0) begin
			stop_with_failure("test file has more expect lines than samples");
		end
		for (int i = 0; i < cmd_count[idx]; i++) begin
			has_lit = (i >= lit_first);
			lit = '0;
			if (has_lit) begin
				lit = lit_list[cmd_lit_start[idx] + i - lit_first];
			end
			if (word == word_t'("idle")) begin
				drive_cycle(1'b1, 1'b0, '0, has_lit, lit);
			end else if (word == word_t'("impulse")) begin
				drive_cycle(1'b1, 1'b1, (i == 0) ? sample_t'(cmd_value[idx]) : '0,
					has_lit, lit);
			end else if (word == word_t'("step")) begin
				drive_cycle(1'b1, 1'b1, sample_t'(cmd_value[idx]), has_lit, lit);
			end else if (word == word_t'("gap")) begin
				take_bits(2, bits);
				gap_len = int'(bits[1:0]);
				for (int j = 0; j < gap_len; j++) begin
					take_bits(19, bits);
					drive_cycle(1'b0, bits[18], sample_t'(bits[17:0]), 1'b0, '0);
				end
				take_bits(19, bits);
				drive_cycle(1'b1, bits[18], sample_t'(bits[17:0]), has_lit, lit);
			end else if (word == word_t'("random")) begin
				take_bits(18, bits);
				drive_cycle(1'b1, 1'b1, sample_t'(bits[17:0]), has_lit, lit);
			end else begin
				stop_with_failure($sformatf("unknown command in test file: %0s", word));
			end
		end
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int waited;
		clk = 1'b0;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		lfsr = 32'd69;
		pending_valid = 0;
		seen_count = 0;
		held_valid = 1'b0;
		held_sample = '0;
		for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
			hist[k] = '0;
		end
		load_tests();
		repeat (10) @(negedge clk);
		reset = 1'b0;
		for (int c = 0; c < cmd_word.size(); c++) begin
			run_command(c);
		end
		// flush until every queued strobe has come out
		waited = 0;
		while (pending_valid > 0) begin
			if (waited >= 100) begin
				stop_with_failure("timed out waiting for the last o_valid strobes");
			end
			drive_cycle(1'b1, 1'b0, '0, 1'b0, '0);
			waited++;
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/fir_filter.sv
// 45-tap symmetric FIR filter, pipelined
// data path and valid tracker run side by side with equal latency

`timescale 1ns/100ps
`default_nettype none

module fir_filter (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  i_clk_ena,
	input  wire logic                  i_valid,
	input  wire fir_data_pkg::sample_t i_sample,
	output logic                       o_valid,
	output fir_data_pkg::sample_t      o_sample
);

	import fir_data_pkg::*;

	// folded taps between pre-adder and multipliers
	fold_vec_t folds;

	// data path, tap line and pre-adder
	fir_fold_line u_fold_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_folds   (folds)
	);

	// data path, multipliers and adder tree
	fir_mac_tree u_mac_tree (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_folds   (folds),
		.o_sample  (o_sample)
	);

	// strobe delayed to line up with o_sample
	fir_valid_track u_valid_track (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

//--- design/fir_valid_track.sv
// FIR valid tracker
// carries the input strobe through a delay equal to the datapath latency

`timescale 1ns/100ps
`default_nettype none

`include "fir_macros.svh"

module fir_valid_track (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic i_clk_ena,
	input  wire logic i_valid,
	output logic      o_valid
);

	// bit 0 is the newest strobe
	logic [`FIR_LATENCY-1:0] valid_pipe;

	// advances only with the datapath registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
		end else if (i_clk_ena) begin
			valid_pipe <= {valid_pipe[`FIR_LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_pipe[`FIR_LATENCY-1];

endmodule

`default_nettype wire

//--- fir_core/fir_mac_tree.sv
// FIR multiply and accumulate
// multiplies each fold by its coefficient, sums the products in a
// registered binary tree and scales the total back to sample width

`timescale 1ns/100ps
`default_nettype none

`include "fir_macros.svh"

module fir_mac_tree (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    i_clk_ena,
	input  wire fir_data_pkg::fold_vec_t i_folds,
	output fir_data_pkg::sample_t        o_sample
);

	import fir_data_pkg::*;
	import fir_coeff_pkg::*;

	// nodes at a tree level, level 0 holds the products
	function automatic int level_size(input int level);
		int n;
		n = `FIR_NUM_UNIQ;
		for (int l = 0; l < level; l++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	// index of a level's first node in the flat node array
	function automatic int level_base(input int level);
		int base;
		base = 0;
		for (int l = 0; l < level; l++) begin
			base += level_size(l);
		end
		return base;
	endfunction

	// 23 + 12 + 6 + 3 + 2 + 1
	localparam int NUM_NODES = level_base(`FIR_TREE_LEVELS + 1);

	product_t prod [`FIR_NUM_UNIQ];
	acc_t     node [NUM_NODES];
	acc_t     scaled;

	// ******************************
	// multipliers
	// ******************************

	// full precision, no truncation of the product
	always_comb begin
		for (int i = 0; i < `FIR_NUM_UNIQ; i++) begin
			prod[i] = product_t'(i_folds[i]) * product_t'(FIR_COEFFS[i]);
		end
	end

	for (genvar i = 0; i < `FIR_NUM_UNIQ; i++) begin : g_mult
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				node[i] <= '0;
			end else if (i_clk_ena) begin
				node[i] <= acc_t'(prod[i]);
			end
		end
	end

	// ******************************
	// adder tree
	// ******************************

	for (genvar lv = 1; lv <= `FIR_TREE_LEVELS; lv++) begin : g_level
		localparam int SRC_BASE = level_base(lv - 1);
		localparam int SRC_SIZE = level_size(lv - 1);
		localparam int DST_BASE = level_base(lv);

		for (genvar i = 0; i < level_size(lv); i++) begin : g_node
			if (2 * i + 1 < SRC_SIZE) begin : g_add
				always_ff @(posedge clk or posedge reset) begin
					if (reset) begin
						node[DST_BASE + i] <= '0;
					end else if (i_clk_ena) begin
						node[DST_BASE + i] <= node[SRC_BASE + 2 * i]
							+ node[SRC_BASE + 2 * i + 1];
					end
				end
			end else begin : g_bye
				// odd one out, delayed to keep the level aligned
				always_ff @(posedge clk or posedge reset) begin
					if (reset) begin
						node[DST_BASE + i] <= '0;
					end else if (i_clk_ena) begin
						node[DST_BASE + i] <= node[SRC_BASE + 2 * i];
					end
				end
			end
		end
	end

	// ******************************
	// output scaling
	// ******************************

	// divide by 2^17, the top bits wrap away
	assign scaled = node[NUM_NODES - 1] >>> `FIR_SCALE_SHIFT;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_sample <= '0;
		end else if (i_clk_ena) begin
			o_sample <= scaled[`FIR_DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- fir_core/fir_fold_line.sv
// FIR tap line with symmetric pre-adder
// shifts one sample per enabled cycle and adds each tap to its mirror
// so only 23 products are needed downstream

`timescale 1ns/100ps
`default_nettype none

`include "fir_macros.svh"

module fir_fold_line (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  i_clk_ena,
	input  wire fir_data_pkg::sample_t i_sample,
	output fir_data_pkg::fold_vec_t    o_folds
);

	import fir_data_pkg::*;

	// newest sample sits at index 0
	sample_t tap [`FIR_NUM_TAPS];

	// ******************************
	// tap line
	// ******************************

	// shifts on every enabled cycle, valid or not
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
				tap[k] <= '0;
			end
		end else if (i_clk_ena) begin
			tap[0] <= i_sample;
			for (int k = 1; k < `FIR_NUM_TAPS; k++) begin
				tap[k] <= tap[k - 1];
			end
		end
	end

	// ******************************
	// pre-adder
	// ******************************

	// tap k pairs with tap 44-k, both share coefficient k
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
				o_folds[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < `FIR_NUM_UNIQ - 1; k++) begin
				o_folds[k] <= fold_t'(tap[k]) + fold_t'(tap[`FIR_NUM_TAPS - 1 - k]);
			end
			// centre tap has no partner, registered as a bye
			o_folds[`FIR_NUM_UNIQ - 1] <= fold_t'(tap[`FIR_NUM_UNIQ - 1]);
		end
	end

endmodule

`default_nettype wire

//--- common/fir_coeff_pkg.sv
// FIR coefficient set
// the 23 unique taps of the symmetric 45-tap response

`default_nettype none

`include "fir_macros.svh"

package fir_coeff_pkg;

	typedef logic signed [`FIR_COEFF_W-1:0] coeff_t;

	// outer tap first, the last entry is the centre of the response
	localparam coeff_t FIR_COEFFS [`FIR_NUM_UNIQ] = '{
		coeff_t'(88),
		coeff_t'(0),
		coeff_t'(-97),
		coeff_t'(-197),
		coeff_t'(-294),
		coeff_t'(-380),
		coeff_t'(-447),
		coeff_t'(-490),
		coeff_t'(-504),
		coeff_t'(-481),
		coeff_t'(-420),
		coeff_t'(-319),
		coeff_t'(-178),
		coeff_t'(0),
		coeff_t'(212),
		coeff_t'(451),
		coeff_t'(710),
		coeff_t'(980),
		coeff_t'(1252),
		coeff_t'(1514),
		coeff_t'(1756),
		coeff_t'(1971),
		// centre tap
		coeff_t'(2147)
	};

endpackage

`default_nettype wire

//--- common/fir_data_pkg.sv
// FIR datapath types
// widths grow from sample through fold and product to the tree sum

`default_nettype none

`include "fir_macros.svh"

package fir_data_pkg;

	// input and output sample
	typedef logic signed [`FIR_DATA_W-1:0] sample_t;

	// pair sum of two mirrored taps, one guard bit
	typedef logic signed [`FIR_DATA_W:0] fold_t;

	// fold times coefficient at full precision
	typedef logic signed [`FIR_DATA_W+`FIR_COEFF_W:0] product_t;

	// one extra bit per tree level so 23 products never overflow
	typedef logic signed [`FIR_DATA_W+`FIR_COEFF_W+`FIR_TREE_LEVELS:0] acc_t;

	// all folds of one step, index 22 is the centre tap
	typedef fold_t fold_vec_t [`FIR_NUM_UNIQ];

endpackage

`default_nettype wire

//--- common/fir_macros.svh
// FIR filter build constants
// tap count, sample and coefficient widths, output scaling and pipeline depth

`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// ******************************
// filter shape
// ******************************

// full tap count, odd so there is a single centre tap
`define FIR_NUM_TAPS 45

// unique coefficients after folding, ceil(taps / 2)
`define FIR_NUM_UNIQ 23

// ******************************
// arithmetic
// ******************************

`define FIR_DATA_W 18
`define FIR_COEFF_W 18

// final sum is divided by 2^17 before it goes out
`define FIR_SCALE_SHIFT 17

// pairwise levels needed to reduce 23 products to one
`define FIR_TREE_LEVELS 5

// ******************************
// timing
// ******************************

// tap + fold + multiply + tree levels + output register
`define FIR_LATENCY 9

`endif
